/* cache_soc_patterns.txt */
// op cached addr wdata strb expected ars
// op 0 ifetch, 1 dread, 2 write, 3 write with aw stalled, 4 wait idle, f end
0 0 00001004 00000000 0 c0de1004 1
0 1 00002048 00000000 0 c0de2048 1
0 1 0000207c 00000000 0 c0de207c 0
2 0 00003000 11223344 5 00000000 0
1 0 00003000 00000000 0 c0223044 1
3 0 00004000 a0000000 f 00000000 0
3 0 00004004 a0000001 f 00000000 0
3 0 00004008 a0000002 f 00000000 0
3 0 0000400c a0000003 f 00000000 0
3 0 00004010 a0000004 f 00000000 0
3 0 00004014 a0000005 f 00000000 0
3 0 00004018 a0000006 f 00000000 0
3 0 0000401c a0000007 f 00000000 0
3 0 00004020 a0000008 f 00000001 0
4 0 00000000 00000000 0 00000001 0
1 0 00004000 00000000 0 a0000000 1
1 0 00004004 00000000 0 a0000001 1
1 0 00004008 00000000 0 a0000002 1
1 0 0000400c 00000000 0 a0000003 1
1 0 00004010 00000000 0 a0000004 1
1 0 00004014 00000000 0 a0000005 1
1 0 00004018 00000000 0 a0000006 1
1 0 0000401c 00000000 0 a0000007 1
1 0 00004020 00000000 0 a0000008 1
2 0 00002050 deadbeef f 00000000 0
0 1 00002050 00000000 0 c0de2050 0
1 0 00002050 00000000 0 deadbeef 1
f 0 00000000 00000000 0 00000000 0

/* cache_soc.f */
cache_pkg.sv
icache.sv
mem_read.sv
mem_write.sv
cache_soc.sv
tb_cache_soc.sv

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing -f cache_soc.f --top-module tb_cache_soc -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log && echo "PASS" && exit 0 ||
{ echo "FAIL"; exit 1; }

/* tb_cache_soc.sv */
`timescale 1ns/1ps

module tb_cache_soc;

    localparam int LINE_WORDS   = 16;
    localparam int ICACHE_LINES = 64;
    localparam int FIFO_DEPTH   = 8;
    localparam int FIELDS       = 7;    // words per pattern line
    localparam int MAX_WORDS    = 512;
    localparam int WAIT_LIMIT   = 400;
    localparam int STALL_WAIT   = 30;
    localparam logic [3:0] ID_INSTR = 4'd0;
    localparam logic [3:0] ID_DATA  = 4'd1;

    logic        i_clk;
    logic        i_rst;
    logic        i_i_valid;
    logic        i_i_cached;
    logic [31:0] i_i_addr;
    logic        o_i_valid;
    logic [31:0] o_i_inst;
    logic        i_d_read;
    logic        i_d_write;
    logic [31:0] i_d_addr;
    logic [31:0] i_d_wdata;
    logic [3:0]  i_d_byteen;
    logic        o_d_valid;
    logic [31:0] o_d_rdata;
    logic        o_idle;
    logic [3:0]  o_arid;
    logic [31:0] o_araddr;
    logic [3:0]  o_arlen;
    logic        o_arvalid;
    logic        i_arready;
    logic [3:0]  i_rid;
    logic [31:0] i_rdata;
    logic        i_rlast;
    logic        i_rvalid;
    logic        o_rready;
    logic [31:0] o_awaddr;
    logic        o_awvalid;
    logic        i_awready;
    logic [31:0] o_wdata;
    logic [3:0]  o_wstrb;
    logic        o_wvalid;
    logic        i_wready;
    logic        i_bvalid;
    logic        o_bready;

    logic [31:0] pat [MAX_WORDS];
    logic [31:0] mem_words [logic [31:0]];    // only written words are kept
    integer      seed;
    int          n_pat;
    int          errors;
    int          tests_failed;
    int          ar_count;
    int          acked_writes;
    int          done_writes;
    logic        hold_aw;
    logic [31:0] last_araddr;
    logic [3:0]  last_arlen;
    logic [3:0]  last_arid;

    // slave model state
    logic        ar_fire, r_fire, aw_fire, w_fire, b_fire;
    int          ar_wait, r_wait, aw_wait, w_wait, b_wait;
    logic        r_active;
    logic [31:0] r_addr;
    logic [3:0]  r_len;
    logic [3:0]  r_id;
    int          r_beat;
    logic        aw_got, w_got;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_strb;

    cache_soc #(
        .LINE_WORDS       (LINE_WORDS),
        .ICACHE_LINES     (ICACHE_LINES),
        .WRITE_FIFO_DEPTH (FIFO_DEPTH)
    ) i_dut (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_i_valid  (i_i_valid),
        .i_i_cached (i_i_cached),
        .i_i_addr   (i_i_addr),
        .o_i_valid  (o_i_valid),
        .o_i_inst   (o_i_inst),
        .i_d_read   (i_d_read),
        .i_d_write  (i_d_write),
        .i_d_addr   (i_d_addr),
        .i_d_wdata  (i_d_wdata),
        .i_d_byteen (i_d_byteen),
        .o_d_valid  (o_d_valid),
        .o_d_rdata  (o_d_rdata),
        .o_idle     (o_idle),
        .o_arid     (o_arid),
        .o_araddr   (o_araddr),
        .o_arlen    (o_arlen),
        .o_arvalid  (o_arvalid),
        .i_arready  (i_arready),
        .i_rid      (i_rid),
        .i_rdata    (i_rdata),
        .i_rlast    (i_rlast),
        .i_rvalid   (i_rvalid),
        .o_rready   (o_rready),
        .o_awaddr   (o_awaddr),
        .o_awvalid  (o_awvalid),
        .i_awready  (i_awready),
        .o_wdata    (o_wdata),
        .o_wstrb    (o_wstrb),
        .o_wvalid   (o_wvalid),
        .i_wready   (i_wready),
        .i_bvalid   (i_bvalid),
        .o_bready   (o_bready)
    );

    always #2 i_clk = ~i_clk;

    function automatic int pick_delay();
        return $random(seed) & 3;
    endfunction

    function automatic logic [31:0] read_mem(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        if (mem_words.exists(a)) begin
            return mem_words[a];
        end
        return a ^ 32'hC0DE0000;    // untouched memory
    endfunction

    task automatic write_mem(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        logic [31:0] v;
        v = read_mem(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                v[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        mem_words[{addr[31:2], 2'b00}] = v;
    endtask

    task automatic compare(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    // AXI slave model that handshakes at the posedge between two falling edges
    always @(negedge i_clk) begin
        if (i_rst) begin
            i_arready = 1'b0;
            i_rvalid  = 1'b0;
            i_rlast   = 1'b0;
            i_awready = 1'b0;
            i_wready  = 1'b0;
            i_bvalid  = 1'b0;
            r_active  = 1'b0;
            aw_got    = 1'b0;
            w_got     = 1'b0;
            ar_wait   = -1;
            r_wait    = -1;
            aw_wait   = -1;
            w_wait    = -1;
            b_wait    = -1;
        end else begin
            if (ar_fire) begin
                i_arready = 1'b0;
                ar_wait   = -1;
                if (o_arid == ID_DATA && acked_writes != done_writes) begin
                    errors++;
                    $display("data read address issued at %0t before posted writes finished",
                             $time);
                end
                ar_count++;
                last_araddr = o_araddr;
                last_arlen  = o_arlen;
                last_arid   = o_arid;
                r_addr      = o_araddr;
                r_len       = o_arlen;
                r_id        = o_arid;
                r_beat      = 0;
                r_active    = 1'b1;
            end else if (o_arvalid && !i_arready) begin
                if (ar_wait < 0) ar_wait = pick_delay();
                if (ar_wait == 0) i_arready = 1'b1;
                else ar_wait--;
            end

            if (r_fire) begin
                i_rvalid = 1'b0;
                r_wait   = -1;
                if (r_beat == int'(r_len)) r_active = 1'b0;
                else r_beat++;
            end
            if (r_active && !i_rvalid) begin
                if (r_wait < 0) r_wait = pick_delay();
                if (r_wait == 0) begin
                    i_rvalid = 1'b1;
                    i_rdata  = read_mem(r_addr + 32'(r_beat * 4));
                    i_rlast  = (r_beat == int'(r_len));
                    i_rid    = r_id;
                end else begin
                    r_wait--;
                end
            end

            if (aw_fire) begin
                i_awready = 1'b0;
                aw_wait   = -1;
                aw_got    = 1'b1;
                wr_addr   = o_awaddr;
            end else if (o_awvalid && !i_awready && !hold_aw) begin
                if (aw_wait < 0) aw_wait = pick_delay();
                if (aw_wait == 0) i_awready = 1'b1;
                else aw_wait--;
            end

            if (w_fire) begin
                i_wready = 1'b0;
                w_wait   = -1;
                w_got    = 1'b1;
                wr_data  = o_wdata;
                wr_strb  = o_wstrb;
            end else if (o_wvalid && !i_wready) begin
                if (w_wait < 0) w_wait = pick_delay();
                if (w_wait == 0) i_wready = 1'b1;
                else w_wait--;
            end

            if (b_fire) begin
                i_bvalid = 1'b0;
                b_wait   = -1;
                aw_got   = 1'b0;
                w_got    = 1'b0;
                done_writes++;
            end else if (aw_got && w_got && !i_bvalid) begin
                if (b_wait < 0) b_wait = pick_delay();
                if (b_wait == 0) begin
                    write_mem(wr_addr, wr_data, wr_strb);
                    i_bvalid = 1'b1;
                end else begin
                    b_wait--;
                end
            end
        end
        ar_fire = o_arvalid && i_arready;    // what the next posedge will transfer
        r_fire  = i_rvalid && o_rready && !i_rst;
        aw_fire = o_awvalid && i_awready;
        w_fire  = o_wvalid && i_wready;
        b_fire  = i_bvalid && o_bready;
    end

    task automatic run_pattern(input int idx);
        logic [31:0] op, cached, addr, wdata, strb, expv, ars;
        logic [31:0] value;
        logic        got;
        logic        stalled;
        logic        idle_start;
        int          cycles;
        int          errs_before;
        begin
            op          = pat[idx*FIELDS];
            cached      = pat[idx*FIELDS+1];
            addr        = pat[idx*FIELDS+2];
            wdata       = pat[idx*FIELDS+3];
            strb        = pat[idx*FIELDS+4];
            expv        = pat[idx*FIELDS+5];
            ars         = pat[idx*FIELDS+6];
            errs_before = errors;
            value       = '0;
            got         = 1'b0;
            stalled     = 1'b0;
            cycles      = 0;
            ar_count    = 0;
            case (op)
                0: begin
                    i_i_valid  = 1'b1;
                    i_i_cached = cached[0];
                    i_i_addr   = addr;
                end
                1: begin
                    i_d_read = 1'b1;
                    i_d_addr = addr;
                end
                2, 3: begin
                    i_d_write  = 1'b1;
                    i_d_addr   = addr;
                    i_d_wdata  = wdata;
                    i_d_byteen = strb[3:0];
                    if (op == 3) hold_aw = 1'b1;    // write address channel stalled
                end
                default: ;
            endcase
            idle_start = o_idle;
            while (!got && cycles < WAIT_LIMIT) begin
                @(negedge i_clk);
                cycles++;
                if (op == 0 && o_i_valid) begin
                    got   = 1'b1;
                    value = o_i_inst;
                end else if (op == 4 && o_idle) begin
                    got = 1'b1;
                end else if (op != 0 && op != 4 && o_d_valid) begin
                    got   = 1'b1;
                    value = o_d_rdata;
                end
                if (op == 3 && !got && cycles == STALL_WAIT && hold_aw) begin
                    hold_aw = 1'b0;
                    stalled = 1'b1;
                end
            end
            i_i_valid = 1'b0;
            i_d_read  = 1'b0;
            i_d_write = 1'b0;
            @(negedge i_clk);    // request stays low for one cycle
            if (!got) begin
                errors++;
                $display("pattern %0d got no response from the DUT", idx);
            end else begin
                case (op)
                    0: begin
                        compare("instruction", value, expv);
                        compare("read bursts", 32'(ar_count), ars);
                        if (ar_count == 1) begin
                            compare("arid", {28'd0, last_arid}, {28'd0, ID_INSTR});
                        end
                        if (cached[0] && ar_count == 1) begin
                            compare("refill address", last_araddr,
                                    addr & ~32'(LINE_WORDS * 4 - 1));
                            compare("refill arlen", {28'd0, last_arlen}, 32'(LINE_WORDS - 1));
                        end else if (cached[0]) begin
                            compare("hit latency", 32'(cycles), 32'd1);
                        end else if (ar_count == 1) begin
                            compare("araddr", last_araddr, addr);
                            compare("arlen", {28'd0, last_arlen}, 32'd0);
                        end
                    end
                    1: begin
                        compare("data", value, expv);
                        compare("read bursts", 32'(ar_count), ars);
                        compare("arid", {28'd0, last_arid}, {28'd0, ID_DATA});
                        compare("araddr", last_araddr, addr);
                        compare("arlen", {28'd0, last_arlen}, 32'd0);
                    end
                    2: acked_writes++;
                    3: begin
                        acked_writes++;
                        compare("write stalled", {31'd0, stalled}, expv);
                    end
                    4: compare("o_idle before drain", {31'd0, idle_start}, 32'd0);
                    default: ;
                endcase
            end
            if (errors != errs_before) tests_failed++;
            $display("test %0d op %0d addr %h: %s", idx + 1, op, addr,
                     (errors == errs_before) ? "ok" : "mismatch");
        end
    endtask

    initial begin
        i_clk        = 1'b0;
        i_rst        = 1'b1;
        i_i_valid    = 1'b0;
        i_i_cached   = 1'b0;
        i_i_addr     = '0;
        i_d_read     = 1'b0;
        i_d_write    = 1'b0;
        i_d_addr     = '0;
        i_d_wdata    = '0;
        i_d_byteen   = '0;
        i_arready    = 1'b0;
        i_rid        = '0;
        i_rdata      = '0;
        i_rlast      = 1'b0;
        i_rvalid     = 1'b0;
        i_awready    = 1'b0;
        i_wready     = 1'b0;
        i_bvalid     = 1'b0;
        seed         = 32'h3042cec2;
        errors       = 0;
        tests_failed = 0;
        acked_writes = 0;
        done_writes  = 0;
        hold_aw      = 1'b0;
        for (int i = 0; i < MAX_WORDS; i++) begin
            pat[i] = 32'hF;
        end
        $readmemh("cache_soc_patterns.txt", pat);
        n_pat = 0;
        while (n_pat < MAX_WORDS / FIELDS && pat[n_pat*FIELDS] != 32'hF) begin
            n_pat++;
        end
        repeat (16) @(negedge i_clk);
        i_rst = 1'b0;
        @(negedge i_clk);
        compare("o_i_valid after reset", {31'd0, o_i_valid}, 32'd0);
        compare("o_d_valid after reset", {31'd0, o_d_valid}, 32'd0);
        compare("o_arvalid after reset", {31'd0, o_arvalid}, 32'd0);
        compare("o_awvalid after reset", {31'd0, o_awvalid}, 32'd0);
        compare("o_wvalid after reset", {31'd0, o_wvalid}, 32'd0);
        compare("o_rready after reset", {31'd0, o_rready}, 32'd0);
        compare("o_bready after reset", {31'd0, o_bready}, 32'd0);
        compare("o_idle after reset", {31'd0, o_idle}, 32'd1);
        if (errors != 0) tests_failed++;
        $display("test 0 reset state: %s", (errors == 0) ? "ok" : "mismatch");
        for (int p = 0; p < n_pat; p++) begin
            run_pattern(p);
        end
        if (n_pat == 0) begin
            errors++;
            $display("no test patterns were read");
        end
        $display("%0d tests run, %0d failed, %0d errors", n_pat + 1, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        @(negedge i_rst);
        repeat (n_pat * 200 + 40) @(posedge i_clk);
        $display("run timed out after %0d cycles", n_pat * 200 + 40);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* cache_soc.sv */
`timescale 1ns/1ps

module cache_soc #(
    parameter int LINE_WORDS       = cache_pkg::LINE_WORDS_DEFAULT,
    parameter int ICACHE_LINES     = cache_pkg::ICACHE_LINES_DEFAULT,
    parameter int WRITE_FIFO_DEPTH = cache_pkg::WRITE_FIFO_DEPTH_DEFAULT
) (
    input  logic              i_clk,
    input  logic              i_rst,

    input  logic              i_i_valid,
    input  logic              i_i_cached,
    input  cache_pkg::word    i_i_addr,
    output logic              o_i_valid,
    output cache_pkg::word    o_i_inst,

    input  logic              i_d_read,
    input  logic              i_d_write,
    input  cache_pkg::word    i_d_addr,
    input  cache_pkg::word    i_d_wdata,
    input  logic [3:0]        i_d_byteen,
    output logic              o_d_valid,
    output cache_pkg::word    o_d_rdata,

    output logic              o_idle,

    output cache_pkg::axi_id  o_arid,
    output cache_pkg::word    o_araddr,
    output cache_pkg::axi_len o_arlen,
    output logic              o_arvalid,
    input  logic              i_arready,

    input  cache_pkg::axi_id  i_rid,
    input  cache_pkg::word    i_rdata,
    input  logic              i_rlast,
    input  logic              i_rvalid,
    output logic              o_rready,

    output cache_pkg::word    o_awaddr,
    output logic              o_awvalid,
    input  logic              i_awready,

    output cache_pkg::word    o_wdata,
    output logic [3:0]        o_wstrb,
    output logic              o_wvalid,
    input  logic              i_wready,

    input  logic              i_bvalid,
    output logic              o_bready
);
    import cache_pkg::*;

    logic w_ic_valid;
    word  w_ic_inst;
    logic w_refill_req;
    word  w_refill_addr;
    logic w_fill_valid;
    word  w_fill_data;
    logic w_fill_last;
    logic w_iu_valid;
    word  w_iu_data;
    logic w_du_valid;
    logic w_rd_idle;
    logic w_wr_accept;
    logic w_wr_empty;

    assign o_i_valid = w_ic_valid || w_iu_valid;
    assign o_i_inst  = w_iu_valid ? w_iu_data : w_ic_inst;    // uncached answer wins
    assign o_d_valid = w_du_valid || w_wr_accept;
    assign o_idle    = w_rd_idle && w_wr_empty;

    icache #(
        .LINE_WORDS   (LINE_WORDS),
        .ICACHE_LINES (ICACHE_LINES)
    ) i_icache (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_req         (i_i_valid && i_i_cached),
        .i_addr        (i_i_addr),
        .o_valid       (w_ic_valid),
        .o_inst        (w_ic_inst),
        .o_refill_req  (w_refill_req),
        .o_refill_addr (w_refill_addr),
        .i_fill_valid  (w_fill_valid),
        .i_fill_data   (w_fill_data),
        .i_fill_last   (w_fill_last)
    );

    mem_read #(
        .LINE_WORDS (LINE_WORDS)
    ) i_mem_read (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_refill_req  (w_refill_req),
        .i_refill_addr (w_refill_addr),
        .o_fill_valid  (w_fill_valid),
        .o_fill_data   (w_fill_data),
        .o_fill_last   (w_fill_last),
        .i_iu_req      (i_i_valid && !i_i_cached),
        .i_iu_addr     (i_i_addr),
        .o_iu_valid    (w_iu_valid),
        .o_iu_data     (w_iu_data),
        .i_du_req      (i_d_read),
        .i_du_addr     (i_d_addr),
        .o_du_valid    (w_du_valid),
        .o_du_data     (o_d_rdata),
        .i_write_empty (w_wr_empty),
        .o_idle        (w_rd_idle),
        .o_arid        (o_arid),
        .o_araddr      (o_araddr),
        .o_arlen       (o_arlen),
        .o_arvalid     (o_arvalid),
        .i_arready     (i_arready),
        .i_rid         (i_rid),
        .i_rdata       (i_rdata),
        .i_rlast       (i_rlast),
        .i_rvalid      (i_rvalid),
        .o_rready      (o_rready)
    );

    mem_write #(
        .WRITE_FIFO_DEPTH (WRITE_FIFO_DEPTH)
    ) i_mem_write (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_we      (i_d_write),
        .i_addr    (i_d_addr),
        .i_data    (i_d_wdata),
        .i_strb    (i_d_byteen),
        .o_accept  (w_wr_accept),
        .o_empty   (w_wr_empty),
        .o_awaddr  (o_awaddr),
        .o_awvalid (o_awvalid),
        .i_awready (i_awready),
        .o_wdata   (o_wdata),
        .o_wstrb   (o_wstrb),
        .o_wvalid  (o_wvalid),
        .i_wready  (i_wready),
        .i_bvalid  (i_bvalid),
        .o_bready  (o_bready)
    );

endmodule

/* mem_write.sv */
`timescale 1ns/1ps

module mem_write #(
    parameter int WRITE_FIFO_DEPTH = cache_pkg::WRITE_FIFO_DEPTH_DEFAULT
) (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_we,
    input  cache_pkg::word i_addr,
    input  cache_pkg::word i_data,
    input  logic [3:0]     i_strb,
    output logic           o_accept,
    output logic           o_empty,
    output cache_pkg::word o_awaddr,
    output logic           o_awvalid,
    input  logic           i_awready,
    output cache_pkg::word o_wdata,
    output logic [3:0]     o_wstrb,
    output logic           o_wvalid,
    input  logic           i_wready,
    input  logic           i_bvalid,
    output logic           o_bready
);
    import cache_pkg::*;

    localparam int                PTR_BITS   = $clog2(WRITE_FIFO_DEPTH);
    localparam logic [PTR_BITS:0] FULL_COUNT = (PTR_BITS + 1)'(WRITE_FIFO_DEPTH);
    localparam logic [PTR_BITS-1:0] LAST_SLOT = PTR_BITS'(WRITE_FIFO_DEPTH - 1);

    word                 r_addr_mem [WRITE_FIFO_DEPTH];
    word                 r_data_mem [WRITE_FIFO_DEPTH];
    logic [3:0]          r_strb_mem [WRITE_FIFO_DEPTH];
    logic [PTR_BITS-1:0] r_wr_ptr;
    logic [PTR_BITS-1:0] r_rd_ptr;
    logic [PTR_BITS:0]   r_count;
    logic                r_head_busy;    // head entry on the bus
    logic                w_push;
    logic                w_pop;

    assign w_push   = i_we && (r_count != FULL_COUNT) && !o_accept;
    assign w_pop    = o_bready && i_bvalid;
    assign o_empty  = (r_count == '0);
    assign o_bready = r_head_busy && !o_awvalid && !o_wvalid;
    assign o_awaddr = r_addr_mem[r_rd_ptr];
    assign o_wdata  = r_data_mem[r_rd_ptr];
    assign o_wstrb  = r_strb_mem[r_rd_ptr];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_wr_ptr    <= '0;
            r_rd_ptr    <= '0;
            r_count     <= '0;
            r_head_busy <= 1'b0;
            o_awvalid   <= 1'b0;
            o_wvalid    <= 1'b0;
            o_accept    <= 1'b0;
        end else begin
            o_accept <= w_push;    // held back while full
            if (w_push) begin
                r_wr_ptr <= (r_wr_ptr == LAST_SLOT) ? '0 : r_wr_ptr + 1'b1;
            end
            if (w_pop) begin
                r_rd_ptr <= (r_rd_ptr == LAST_SLOT) ? '0 : r_rd_ptr + 1'b1;
            end
            if (w_push && !w_pop) begin
                r_count <= r_count + 1'b1;
            end else if (w_pop && !w_push) begin
                r_count <= r_count - 1'b1;
            end

            if (!r_head_busy && r_count != '0) begin
                r_head_busy <= 1'b1;
                o_awvalid   <= 1'b1;
                o_wvalid    <= 1'b1;
            end else begin
                if (o_awvalid && i_awready) begin
                    o_awvalid <= 1'b0;
                end
                if (o_wvalid && i_wready) begin
                    o_wvalid <= 1'b0;
                end
                if (w_pop) begin
                    r_head_busy <= 1'b0;    // entry retired on B
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_push) begin
            r_addr_mem[r_wr_ptr] <= i_addr;
            r_data_mem[r_wr_ptr] <= i_data;
            r_strb_mem[r_wr_ptr] <= i_strb;
        end
    end

endmodule

/* mem_read.sv */
`timescale 1ns/1ps

module mem_read #(
    parameter int LINE_WORDS = cache_pkg::LINE_WORDS_DEFAULT
) (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_refill_req,
    input  cache_pkg::word    i_refill_addr,
    output logic              o_fill_valid,
    output cache_pkg::word    o_fill_data,
    output logic              o_fill_last,
    input  logic              i_iu_req,
    input  cache_pkg::word    i_iu_addr,
    output logic              o_iu_valid,
    output cache_pkg::word    o_iu_data,
    input  logic              i_du_req,
    input  cache_pkg::word    i_du_addr,
    output logic              o_du_valid,
    output cache_pkg::word    o_du_data,
    input  logic              i_write_empty,
    output logic              o_idle,
    output cache_pkg::axi_id  o_arid,
    output cache_pkg::word    o_araddr,
    output cache_pkg::axi_len o_arlen,
    output logic              o_arvalid,
    input  logic              i_arready,
    input  cache_pkg::axi_id  i_rid,
    input  cache_pkg::word    i_rdata,
    input  logic              i_rlast,
    input  logic              i_rvalid,
    output logic              o_rready
);
    import cache_pkg::*;

    localparam axi_len LINE_LEN = axi_len'(LINE_WORDS - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_AR,
        S_R
    } state_t;

    typedef enum logic [1:0] {
        SRC_FILL,
        SRC_IU,
        SRC_DU
    } src_t;

    state_t r_state;
    src_t   r_src;
    logic   r_busy;    // answer cycle
    logic   w_du_go;
    logic   w_beat;
    logic   w_done;

    assign w_du_go = i_du_req && i_write_empty;    // no read overtakes a posted write
    assign w_beat  = o_rready && i_rvalid && (i_rid == o_arid);
    assign w_done  = w_beat && i_rlast;

    assign o_rready     = (r_state == S_R);
    assign o_idle       = (r_state == S_IDLE) && !r_busy;
    assign o_fill_valid = w_beat && (r_src == SRC_FILL);
    assign o_fill_data  = i_rdata;
    assign o_fill_last  = i_rlast;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_state    <= S_IDLE;
            r_busy     <= 1'b0;
            o_arvalid  <= 1'b0;
            o_iu_valid <= 1'b0;
            o_du_valid <= 1'b0;
        end else begin
            r_busy     <= 1'b0;
            o_iu_valid <= 1'b0;
            o_du_valid <= 1'b0;
            case (r_state)
                S_IDLE: begin
                    if (!r_busy && (w_du_go || i_refill_req || i_iu_req)) begin
                        r_state   <= S_AR;
                        o_arvalid <= 1'b1;
                    end
                end
                S_AR: begin
                    if (i_arready) begin
                        o_arvalid <= 1'b0;
                        r_state   <= S_R;
                    end
                end
                S_R: begin
                    if (w_done) begin
                        r_state    <= S_IDLE;
                        r_busy     <= 1'b1;
                        o_iu_valid <= (r_src == SRC_IU);
                        o_du_valid <= (r_src == SRC_DU);
                    end
                end
                default: r_state <= S_IDLE;
            endcase
        end
    end

    // data side first, refill before uncached fetch
    always_ff @(posedge i_clk) begin
        if (r_state == S_IDLE && !r_busy) begin
            if (w_du_go) begin
                r_src    <= SRC_DU;
                o_arid   <= axi_id_data;
                o_araddr <= i_du_addr;
                o_arlen  <= '0;
            end else if (i_refill_req) begin
                r_src    <= SRC_FILL;
                o_arid   <= axi_id_instr;
                o_araddr <= i_refill_addr;
                o_arlen  <= LINE_LEN;
            end else begin
                r_src    <= SRC_IU;
                o_arid   <= axi_id_instr;
                o_araddr <= i_iu_addr;
                o_arlen  <= '0;
            end
        end
        if (w_done && r_src == SRC_IU) begin
            o_iu_data <= i_rdata;
        end
        if (w_done && r_src == SRC_DU) begin
            o_du_data <= i_rdata;
        end
    end

endmodule

/* icache.sv */
`timescale 1ns/1ps

module icache #(
    parameter int LINE_WORDS   = cache_pkg::LINE_WORDS_DEFAULT,
    parameter int ICACHE_LINES = cache_pkg::ICACHE_LINES_DEFAULT
) (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_req,
    input  cache_pkg::word i_addr,
    output logic           o_valid,
    output cache_pkg::word o_inst,
    output logic           o_refill_req,
    output cache_pkg::word o_refill_addr,
    input  logic           i_fill_valid,
    input  cache_pkg::word i_fill_data,
    input  logic           i_fill_last
);
    import cache_pkg::*;

    localparam int OFF_BITS = $clog2(LINE_WORDS);
    localparam int IDX_BITS = $clog2(ICACHE_LINES);
    localparam int IDX_LSB  = BYTE_OFFSET_BITS + OFF_BITS;
    localparam int TAG_LSB  = IDX_LSB + IDX_BITS;
    localparam int TAG_BITS = 32 - TAG_LSB;

    typedef enum logic [1:0] {
        S_LOOKUP,
        S_REFILL,
        S_RESP
    } state_t;

    state_t                  r_state;
    logic [TAG_BITS-1:0]     r_tag_mem [ICACHE_LINES];
    logic [ICACHE_LINES-1:0] r_valid_bits;
    word                     r_data_mem [ICACHE_LINES*LINE_WORDS];
    word                     r_line_addr;
    logic [OFF_BITS-1:0]     r_req_off;
    logic [OFF_BITS-1:0]     r_fill_cnt;
    word                     r_inst;

    logic [OFF_BITS-1:0]     w_off;
    logic [IDX_BITS-1:0]     w_idx;
    logic [TAG_BITS-1:0]     w_tag;
    logic [IDX_BITS-1:0]     w_fill_idx;
    logic                    w_hit;

    assign w_off      = i_addr[BYTE_OFFSET_BITS +: OFF_BITS];
    assign w_idx      = i_addr[IDX_LSB +: IDX_BITS];
    assign w_tag      = i_addr[TAG_LSB +: TAG_BITS];
    assign w_fill_idx = r_line_addr[IDX_LSB +: IDX_BITS];
    assign w_hit      = r_valid_bits[w_idx] && (r_tag_mem[w_idx] == w_tag);

    assign o_valid       = (r_state == S_RESP);    // one cycle, then back to lookup
    assign o_inst        = r_inst;
    assign o_refill_req  = (r_state == S_REFILL);
    assign o_refill_addr = r_line_addr;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_state      <= S_LOOKUP;
            r_valid_bits <= '0;
            r_fill_cnt   <= '0;
        end else begin
            case (r_state)
                S_LOOKUP: begin
                    if (i_req && w_hit) begin
                        r_state <= S_RESP;
                    end else if (i_req) begin
                        r_state    <= S_REFILL;
                        r_fill_cnt <= '0;
                    end
                end
                S_REFILL: begin
                    if (i_fill_valid) begin
                        r_fill_cnt <= r_fill_cnt + 1'b1;
                        if (i_fill_last) begin
                            r_valid_bits[w_fill_idx] <= 1'b1;
                            r_state                  <= S_RESP;
                        end
                    end
                end
                S_RESP: r_state <= S_LOOKUP;
                default: r_state <= S_LOOKUP;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (r_state == S_LOOKUP && i_req) begin
            r_line_addr <= {i_addr[31:IDX_LSB], {IDX_LSB{1'b0}}};
            r_req_off   <= w_off;
            r_inst      <= r_data_mem[{w_idx, w_off}];    // kept only on a hit
        end
        if (r_state == S_REFILL && i_fill_valid) begin
            r_data_mem[{w_fill_idx, r_fill_cnt}] <= i_fill_data;
            if (r_fill_cnt == r_req_off) begin
                r_inst <= i_fill_data;    // catch the wanted word in passing
            end
            if (i_fill_last) begin
                r_tag_mem[w_fill_idx] <= r_line_addr[TAG_LSB +: TAG_BITS];
            end
        end
    end

endmodule

/* cache_pkg.sv */
package cache_pkg;

    typedef logic [31:0] word;
    typedef logic [3:0]  axi_id;
    typedef logic [3:0]  axi_len;    // AXI3 burst length field

    // read burst owners that the R channel checks again
    localparam axi_id axi_id_instr = 4'd0;
    localparam axi_id axi_id_data  = 4'd1;

    localparam int BYTE_OFFSET_BITS = 2;    // 4-byte beats

    localparam int LINE_WORDS_DEFAULT       = 16;
    localparam int ICACHE_LINES_DEFAULT     = 64;
    localparam int WRITE_FIFO_DEPTH_DEFAULT = 8;

endpackage
